// File: rvv_rob.f
source/rvv_rob_pkg.sv
source/rvv_rob_info_fifo.sv
source/rvv_rob.sv
source/rvv_retire.sv
source/rvv_rob_top.sv
tb/tb_rvv_rob_top.sv

// File: Bender.yml
package:
  name: rvv_rob

sources:
  - source/rvv_rob_pkg.sv
  - source/rvv_rob_info_fifo.sv
  - source/rvv_rob.sv
  - source/rvv_retire.sv
  - source/rvv_rob_top.sv
  - target: test
    files:
      - tb/tb_rvv_rob_top.sv

// File: tb/tb_rvv_rob_top.sv
// testbench for the ROB subsystem: reference model, concurrent checks and random traffic
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_rob_top;

  localparam int N_TESTS         = 6;
  localparam int WATCHDOG_CYCLES = N_TESTS * 200 + 100;

  logic                                               clk;
  logic                                               rst_n;
  logic [rvv_rob_pkg::NUM_DP_UOP-1:0]                 dp_valid;
  rvv_rob_pkg::dp2rob_t [rvv_rob_pkg::NUM_DP_UOP-1:0] dp_uop;
  logic [rvv_rob_pkg::NUM_DP_UOP-1:0]                 dp_ready;
  rvv_rob_pkg::rob_idx_t                              dp_index;
  logic [rvv_rob_pkg::NUM_PU-1:0]                     pu_valid;
  rvv_rob_pkg::pu2rob_t [rvv_rob_pkg::NUM_PU-1:0]     pu_res;
  logic [rvv_rob_pkg::NUM_PU-1:0]                     pu_ready;
  logic                                               trap_valid;
  rvv_rob_pkg::trap_t                                 trap;
  logic                                               trap_ready;
  logic                                               rt_stall;
  logic [rvv_rob_pkg::VREG_IDX_W-1:0]                 rd_index;
  logic [rvv_rob_pkg::DATA_W-1:0]                     rd_data;
  logic                                               sat;
  logic                                               flush;
  rvv_rob_pkg::rob2dp_t [rvv_rob_pkg::ROB_DEPTH-1:0]  bypass;

  // model state, indexed by ROB entry
  int                                 m_cnt;
  rvv_rob_pkg::rob_idx_t              m_rptr;
  rvv_rob_pkg::rob_idx_t              m_wptr;
  logic [rvv_rob_pkg::ROB_DEPTH-1:0]  m_done;
  logic [rvv_rob_pkg::ROB_DEPTH-1:0]  m_trap;
  logic [rvv_rob_pkg::ROB_DEPTH-1:0]  m_wv;
  logic [rvv_rob_pkg::ROB_DEPTH-1:0]  m_rwv;
  logic [rvv_rob_pkg::ROB_DEPTH-1:0]  m_vx;
  logic [rvv_rob_pkg::VREG_IDX_W-1:0] m_widx [rvv_rob_pkg::ROB_DEPTH];
  logic [rvv_rob_pkg::DATA_W-1:0]     m_data [rvv_rob_pkg::ROB_DEPTH];
  logic [rvv_rob_pkg::DATA_W-1:0]     m_vrf  [rvv_rob_pkg::VREG_NUM];
  logic                               m_sat;

  // expected outputs of the current cycle
  logic [rvv_rob_pkg::NUM_RT_UOP-1:0]                exp_rtv;
  logic [rvv_rob_pkg::NUM_RT_UOP-1:0]                exp_ret;
  logic [rvv_rob_pkg::NUM_DP_UOP-1:0]                exp_dp_ready;
  logic                                              exp_flush;
  logic [rvv_rob_pkg::DATA_W-1:0]                    exp_rd_data;
  rvv_rob_pkg::rob2dp_t [rvv_rob_pkg::ROB_DEPTH-1:0] exp_byp;
  rvv_rob_pkg::rob2dp_t [rvv_rob_pkg::ROB_DEPTH-1:0] byp_view;

  int          n_dp_err;
  int          n_rt_err;
  int          n_byp_err;
  int unsigned tag_cnt;

  rvv_rob_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .dp_valid   (dp_valid),
    .dp_uop     (dp_uop),
    .dp_ready   (dp_ready),
    .dp_index   (dp_index),
    .pu_valid   (pu_valid),
    .pu_res     (pu_res),
    .pu_ready   (pu_ready),
    .trap_valid (trap_valid),
    .trap       (trap),
    .trap_ready (trap_ready),
    .rt_stall   (rt_stall),
    .rd_index   (rd_index),
    .rd_data    (rd_data),
    .sat        (sat),
    .flush      (flush),
    .bypass     (bypass)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // retire rule: oldest first, second only behind an untrapped done oldest
  always_comb begin
    rvv_rob_pkg::rob_idx_t i1;
    rvv_rob_pkg::rob_idx_t idx;
    i1 = m_rptr + 3'd1;
    exp_rtv[0]   = (m_cnt > 0) && m_done[m_rptr];
    exp_rtv[1]   = exp_rtv[0] && (m_cnt > 1) && m_done[i1] && !m_trap[m_rptr];
    exp_ret      = rt_stall ? 2'b00 : exp_rtv;
    exp_flush    = (exp_ret[0] && m_trap[m_rptr]) || (exp_ret[1] && m_trap[i1]);
    exp_dp_ready[0] = (m_cnt < rvv_rob_pkg::ROB_DEPTH) && !exp_flush;
    exp_dp_ready[1] = (m_cnt < rvv_rob_pkg::ROB_DEPTH - 1) && !exp_flush;
    exp_rd_data  = m_vrf[rd_index];
    // only fields that carry meaning are compared
    for (int i = 0; i < rvv_rob_pkg::ROB_DEPTH; i++) begin
      idx = m_rptr + rvv_rob_pkg::rob_idx_t'(i);
      exp_byp[i]        = '0;
      byp_view[i]       = '0;
      exp_byp[i].valid  = (i < m_cnt);
      byp_view[i].valid = bypass[i].valid;
      if (i < m_cnt) begin
        exp_byp[i].w_valid  = m_wv[idx] && m_done[idx] && m_rwv[idx];
        exp_byp[i].w_index  = m_widx[idx];
        byp_view[i].w_valid = bypass[i].w_valid;
        byp_view[i].w_index = bypass[i].w_index;
        if (exp_byp[i].w_valid) begin
          exp_byp[i].w_data  = m_data[idx];
          byp_view[i].w_data = bypass[i].w_data;
        end
      end
    end
  end

  always @(posedge clk or negedge rst_n) begin
    logic [rvv_rob_pkg::NUM_RT_UOP-1:0] ret;
    logic [rvv_rob_pkg::NUM_DP_UOP-1:0] acc;
    logic                               fl;
    rvv_rob_pkg::rob_idx_t              idx;
    if (!rst_n) begin
      m_cnt  = 0;
      m_rptr = '0;
      m_wptr = '0;
      m_done = '0;
      m_trap = '0;
      m_sat  = 1'b0;
      for (int r = 0; r < rvv_rob_pkg::VREG_NUM; r++) begin
        m_vrf[r] = '0;
      end
    end else begin
      ret = exp_ret;
      fl  = exp_flush;
      acc = dp_valid & exp_dp_ready;
      // slot 1 applied last
      for (int k = 0; k < rvv_rob_pkg::NUM_RT_UOP; k++) begin
        if (ret[k]) begin
          idx = m_rptr + rvv_rob_pkg::rob_idx_t'(k);
          if (m_wv[idx] && m_rwv[idx]) begin
            m_vrf[m_widx[idx]] = m_data[idx];
          end
          m_sat       = m_sat | m_vx[idx];
          m_done[idx] = 1'b0;
        end
      end
      if (fl) begin
        m_done = '0;
        m_trap = '0;
        m_rptr = m_wptr;
        m_cnt  = 0;
      end else begin
        m_rptr = m_rptr + rvv_rob_pkg::rob_idx_t'($countones(ret));
        m_cnt  = m_cnt - $countones(ret);
        for (int p = 0; p < rvv_rob_pkg::NUM_PU; p++) begin
          if (pu_valid[p]) begin
            idx         = pu_res[p].rob_entry;
            m_done[idx] = 1'b1;
            m_rwv[idx]  = pu_res[p].w_valid;
            m_data[idx] = pu_res[p].w_data;
            m_vx[idx]   = pu_res[p].vxsat;
          end
        end
        if (trap_valid) begin
          m_trap[trap.trap_rob_entry] = 1'b1;
        end
        for (int k = 0; k < rvv_rob_pkg::NUM_DP_UOP; k++) begin
          if (acc[k]) begin
            idx         = m_wptr + rvv_rob_pkg::rob_idx_t'(k);
            m_wv[idx]   = dp_uop[k].w_valid;
            m_widx[idx] = dp_uop[k].w_index;
          end
        end
        m_wptr = m_wptr + rvv_rob_pkg::rob_idx_t'($countones(acc));
        m_cnt  = m_cnt + $countones(acc);
      end
    end
  end

  a_dp_ready: assert property (@(posedge clk) disable iff (!rst_n) dp_ready == exp_dp_ready)
    else begin
      n_dp_err++;
      $display("ERROR dp_ready: got %h exp %h", $sampled(dp_ready), $sampled(exp_dp_ready));
    end

  a_dp_index: assert property (@(posedge clk) disable iff (!rst_n) dp_index == m_wptr)
    else begin
      n_dp_err++;
      $display("ERROR dp_index: got %h exp %h", $sampled(dp_index), $sampled(m_wptr));
    end

  a_ready_high: assert property (@(posedge clk) disable iff (!rst_n)
    (pu_ready == '1) && trap_ready)
    else begin
      n_dp_err++;
      $display("ERROR pu_ready/trap_ready: got %h/%h exp 3/1",
               $sampled(pu_ready), $sampled(trap_ready));
    end

  a_flush: assert property (@(posedge clk) disable iff (!rst_n) flush == exp_flush)
    else begin
      n_rt_err++;
      $display("ERROR flush: got %h exp %h", $sampled(flush), $sampled(exp_flush));
    end

  a_rd_data: assert property (@(posedge clk) disable iff (!rst_n) rd_data == exp_rd_data)
    else begin
      n_rt_err++;
      $display("ERROR rd_data[%h]: got %h exp %h", $sampled(rd_index),
               $sampled(rd_data), $sampled(exp_rd_data));
    end

  a_sat: assert property (@(posedge clk) disable iff (!rst_n) sat == m_sat)
    else begin
      n_rt_err++;
      $display("ERROR sat: got %h exp %h", $sampled(sat), $sampled(m_sat));
    end

  a_bypass: assert property (@(posedge clk) disable iff (!rst_n) byp_view == exp_byp)
    else begin
      n_byp_err++;
      $display("ERROR bypass: got %h exp %h", $sampled(byp_view), $sampled(exp_byp));
    end

  // results and traps go only to held entries that still wait for a result
  task automatic drive_cycle(input int push_pct, input int res_pct, input int trap_pct,
                             input bit hold_oldest, input bit stall);
    rvv_rob_pkg::rob_idx_t cand [$];
    rvv_rob_pkg::rob_idx_t idx;
    int                    j;
    dp_valid   = '0;
    pu_valid   = '0;
    trap_valid = 1'b0;
    rt_stall   = stall;
    rd_index   = rvv_rob_pkg::VREG_IDX_W'($urandom_range(rvv_rob_pkg::VREG_NUM - 1));
    for (int k = 0; k < rvv_rob_pkg::NUM_DP_UOP; k++) begin
      dp_uop[k].w_valid = ($urandom_range(7) != 0);
      dp_uop[k].w_index = rvv_rob_pkg::VREG_IDX_W'($urandom_range(rvv_rob_pkg::VREG_NUM - 1));
      dp_uop[k].tag     = rvv_rob_pkg::TAG_W'(tag_cnt + k);
    end
    if ($urandom_range(99) < push_pct) begin
      dp_valid = ($urandom_range(1) == 1) ? 2'b11 : 2'b01;
      tag_cnt  = tag_cnt + $countones(dp_valid);
    end
    for (int i = 0; i < m_cnt; i++) begin
      idx = m_rptr + rvv_rob_pkg::rob_idx_t'(i);
      if (!m_done[idx] && !(hold_oldest && i == 0)) begin
        cand.push_back(idx);
      end
    end
    for (int p = 0; p < rvv_rob_pkg::NUM_PU; p++) begin
      if (cand.size() > 0 && $urandom_range(99) < res_pct) begin
        j                   = $urandom_range(cand.size() - 1);
        pu_valid[p]         = 1'b1;
        pu_res[p].rob_entry = cand[j];
        pu_res[p].w_valid   = ($urandom_range(7) != 0);
        pu_res[p].w_data    = $urandom;
        pu_res[p].vxsat     = ($urandom_range(15) == 0);
        cand.delete(j);
      end
    end
    if (cand.size() > 0 && m_trap == '0 && $urandom_range(99) < trap_pct) begin
      trap_valid          = 1'b1;
      trap.trap_rob_entry = cand[$urandom_range(cand.size() - 1)];
    end
  endtask

  task automatic run_cycles(input int n, input int push_pct, input int res_pct,
                            input int trap_pct, input bit hold_oldest, input bit stall);
    for (int c = 0; c < n; c++) begin
      @(posedge clk);
      #1;
      drive_cycle(push_pct, res_pct, trap_pct, hold_oldest, stall);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n      = 1'b0;
    dp_valid   = '0;
    pu_valid   = '0;
    trap_valid = 1'b0;
    rt_stall   = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic report_counts();
    $display("error counts: dispatch %0d, retire %0d, bypass %0d",
             n_dp_err, n_rt_err, n_byp_err);
  endtask

  initial begin
    void'($urandom(32'h947c));
    rst_n      = 1'b0;
    dp_valid   = '0;
    dp_uop     = '0;
    pu_valid   = '0;
    pu_res     = '0;
    trap_valid = 1'b0;
    trap       = '0;
    rt_stall   = 1'b0;
    rd_index   = '0;
    n_dp_err   = 0;
    n_rt_err   = 0;
    n_byp_err  = 0;
    tag_cnt    = 0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // results in random order
    run_cycles(150, 70, 60, 0, 1'b0, 1'b0);
    // oldest held back, then drained
    run_cycles(20, 60, 70, 0, 1'b1, 1'b0);
    run_cycles(20, 0, 100, 0, 1'b0, 1'b0);
    // fill to full with no results
    run_cycles(12, 100, 0, 0, 1'b0, 1'b0);
    run_cycles(20, 0, 100, 0, 1'b0, 1'b0);
    // traps and flushes
    run_cycles(150, 60, 50, 10, 1'b0, 1'b0);
    // stall with results arriving, then release
    run_cycles(10, 80, 0, 0, 1'b0, 1'b0);
    run_cycles(20, 60, 70, 0, 1'b0, 1'b1);
    run_cycles(30, 50, 70, 0, 1'b0, 1'b0);
    // saturation then a reset clears it
    run_cycles(100, 60, 60, 5, 1'b0, 1'b0);
    apply_reset();
    run_cycles(20, 60, 60, 0, 1'b0, 1'b0);
    run_cycles(10, 0, 100, 0, 1'b0, 1'b0);
    @(posedge clk);
    #1;
    report_counts();
    if (n_dp_err + n_rt_err + n_byp_err == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    report_counts();
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/rvv_rob_top.sv
// ROB subsystem top: reorder buffer feeding the retire stage and its VRF
`timescale 1ns/1ps
`default_nettype none

module rvv_rob_top (
  input  wire logic                                                clk,
  input  wire logic                                                rst_n,
  input  wire logic [rvv_rob_pkg::NUM_DP_UOP-1:0]                  dp_valid,
  input  wire rvv_rob_pkg::dp2rob_t [rvv_rob_pkg::NUM_DP_UOP-1:0]  dp_uop,
  output logic [rvv_rob_pkg::NUM_DP_UOP-1:0]                       dp_ready,
  output rvv_rob_pkg::rob_idx_t                                    dp_index,
  input  wire logic [rvv_rob_pkg::NUM_PU-1:0]                      pu_valid,
  input  wire rvv_rob_pkg::pu2rob_t [rvv_rob_pkg::NUM_PU-1:0]      pu_res,
  output logic [rvv_rob_pkg::NUM_PU-1:0]                           pu_ready,
  input  wire logic                                                trap_valid,
  input  wire rvv_rob_pkg::trap_t                                  trap,
  output logic                                                     trap_ready,
  input  wire logic                                                rt_stall,
  input  wire logic [rvv_rob_pkg::VREG_IDX_W-1:0]                  rd_index,
  output logic [rvv_rob_pkg::DATA_W-1:0]                           rd_data,
  output logic                                                     sat,
  output logic                                                     flush,
  output rvv_rob_pkg::rob2dp_t [rvv_rob_pkg::ROB_DEPTH-1:0]        bypass
);

  // ROB to retire channel
  logic [rvv_rob_pkg::NUM_RT_UOP-1:0]                 rt_valid;
  rvv_rob_pkg::rob2rt_t [rvv_rob_pkg::NUM_RT_UOP-1:0] rt_uop;
  logic [rvv_rob_pkg::NUM_RT_UOP-1:0]                 rt_ready;

  rvv_rob i_rob (
    .clk        (clk),
    .rst_n      (rst_n),
    .dp_valid   (dp_valid),
    .dp_uop     (dp_uop),
    .dp_ready   (dp_ready),
    .dp_index   (dp_index),
    .pu_valid   (pu_valid),
    .pu_res     (pu_res),
    .pu_ready   (pu_ready),
    .trap_valid (trap_valid),
    .trap       (trap),
    .trap_ready (trap_ready),
    .rt_valid   (rt_valid),
    .rt_uop     (rt_uop),
    .rt_ready   (rt_ready),
    .bypass     (bypass),
    .flush      (flush)
  );

  rvv_retire i_retire (
    .clk      (clk),
    .rst_n    (rst_n),
    .rt_valid (rt_valid),
    .rt_uop   (rt_uop),
    .rt_stall (rt_stall),
    .rt_ready (rt_ready),
    .rd_index (rd_index),
    .rd_data  (rd_data),
    .sat      (sat)
  );

endmodule

`default_nettype wire

// File: source/rvv_retire.sv
// retire stage that writes retired results into the VRF and keeps the sticky saturation flag
`timescale 1ns/1ps
`default_nettype none

module rvv_retire (
  input  wire logic                                               clk,
  input  wire logic                                               rst_n,
  input  wire logic [rvv_rob_pkg::NUM_RT_UOP-1:0]                 rt_valid,
  input  wire rvv_rob_pkg::rob2rt_t [rvv_rob_pkg::NUM_RT_UOP-1:0] rt_uop,
  input  wire logic                                               rt_stall,
  output logic [rvv_rob_pkg::NUM_RT_UOP-1:0]                      rt_ready,
  input  wire logic [rvv_rob_pkg::VREG_IDX_W-1:0]                 rd_index,
  output logic [rvv_rob_pkg::DATA_W-1:0]                          rd_data,
  output logic                                                    sat
);

  logic [rvv_rob_pkg::DATA_W-1:0]     vrf [rvv_rob_pkg::VREG_NUM];
  logic [rvv_rob_pkg::NUM_RT_UOP-1:0] accept;
  logic [rvv_rob_pkg::NUM_RT_UOP-1:0] acc_sat;

  assign rt_ready = rt_stall ? '0 : '1;
  assign accept   = rt_valid & rt_ready;

  for (genvar k = 0; k < rvv_rob_pkg::NUM_RT_UOP; k++) begin : g_sat
    assign acc_sat[k] = accept[k] & rt_uop[k].vxsat;
  end

  // younger slot applied last and wins on the same register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < rvv_rob_pkg::VREG_NUM; r++) begin
        vrf[r] <= '0;
      end
    end else begin
      for (int k = 0; k < rvv_rob_pkg::NUM_RT_UOP; k++) begin
        if (accept[k] && rt_uop[k].w_valid) begin
          vrf[rt_uop[k].w_index] <= rt_uop[k].w_data;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sat <= 1'b0;
    end else if (|acc_sat) begin
      sat <= 1'b1;
    end
  end

  assign rd_data = vrf[rd_index];

  // slot 1 only offered behind slot 0
  a_rt_in_order: assert property (@(posedge clk) disable iff (!rst_n)
    rt_valid[1] |-> rt_valid[0]);

endmodule

`default_nettype wire

// File: source/rvv_rob.sv
// reorder buffer: result memory, done and trap tracking, in-order retire and dispatch bypass
`timescale 1ns/1ps
`default_nettype none

module rvv_rob (
  input  wire logic                                                clk,
  input  wire logic                                                rst_n,
  input  wire logic [rvv_rob_pkg::NUM_DP_UOP-1:0]                  dp_valid,
  input  wire rvv_rob_pkg::dp2rob_t [rvv_rob_pkg::NUM_DP_UOP-1:0]  dp_uop,
  output logic [rvv_rob_pkg::NUM_DP_UOP-1:0]                       dp_ready,
  output rvv_rob_pkg::rob_idx_t                                    dp_index,
  input  wire logic [rvv_rob_pkg::NUM_PU-1:0]                      pu_valid,
  input  wire rvv_rob_pkg::pu2rob_t [rvv_rob_pkg::NUM_PU-1:0]      pu_res,
  output logic [rvv_rob_pkg::NUM_PU-1:0]                           pu_ready,
  input  wire logic                                                trap_valid,
  input  wire rvv_rob_pkg::trap_t                                  trap,
  output logic                                                     trap_ready,
  output logic [rvv_rob_pkg::NUM_RT_UOP-1:0]                       rt_valid,
  output rvv_rob_pkg::rob2rt_t [rvv_rob_pkg::NUM_RT_UOP-1:0]       rt_uop,
  input  wire logic [rvv_rob_pkg::NUM_RT_UOP-1:0]                  rt_ready,
  output rvv_rob_pkg::rob2dp_t [rvv_rob_pkg::ROB_DEPTH-1:0]        bypass,
  output logic                                                     flush
);

  // uop info, in program order from the oldest
  rvv_rob_pkg::dp2rob_t [rvv_rob_pkg::NUM_RT_UOP-1:0] head_uop;
  rvv_rob_pkg::dp2rob_t [rvv_rob_pkg::ROB_DEPTH-1:0]  uop_info;
  logic [rvv_rob_pkg::ROB_DEPTH-1:0]                  entry_valid;
  rvv_rob_pkg::rob_idx_t                              wptr;
  rvv_rob_pkg::rob_idx_t                              rptr;
  logic                                               lt_depth;
  logic                                               lt_depth_m1;

  logic [rvv_rob_pkg::NUM_DP_UOP-1:0] push;
  logic [rvv_rob_pkg::NUM_RT_UOP-1:0] pop;
  logic [rvv_rob_pkg::NUM_PU-1:0]     pu_fire;
  logic [rvv_rob_pkg::NUM_RT_UOP-1:0] rt_trap;

  // result memory, indexed by entry
  logic                           res_w_valid [rvv_rob_pkg::ROB_DEPTH];
  logic [rvv_rob_pkg::DATA_W-1:0] res_data    [rvv_rob_pkg::ROB_DEPTH];
  logic                           res_vxsat   [rvv_rob_pkg::ROB_DEPTH];
  logic [rvv_rob_pkg::ROB_DEPTH-1:0] done;
  logic [rvv_rob_pkg::ROB_DEPTH-1:0] trap_flag;
  rvv_rob_pkg::rob_idx_t ord_idx [rvv_rob_pkg::ROB_DEPTH];

  rvv_rob_info_fifo i_info_fifo (
    .clk               (clk),
    .rst_n             (rst_n),
    .push              (push),
    .datain            (dp_uop),
    .pop               (pop),
    .clear             (flush),
    .count_lt_depth    (lt_depth),
    .count_lt_depth_m1 (lt_depth_m1),
    .dataout           (head_uop),
    .fifo_data         (uop_info),
    .entry_valid       (entry_valid),
    .wptr              (wptr),
    .rptr              (rptr)
  );

  // a flushing cycle refuses new uops
  assign dp_ready[0] = lt_depth & ~flush;
  assign dp_ready[1] = lt_depth_m1 & ~flush;
  assign dp_index    = wptr;
  assign push        = dp_valid & dp_ready;

  assign pu_ready   = '1;
  assign trap_ready = 1'b1;
  assign pu_fire    = pu_valid & pu_ready;
  assign pop        = rt_valid & rt_ready;

  for (genvar i = 0; i < rvv_rob_pkg::ROB_DEPTH; i++) begin : g_ord
    assign ord_idx[i] = rptr + rvv_rob_pkg::rob_idx_t'(i);
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < rvv_rob_pkg::NUM_PU; k++) begin
      if (pu_fire[k]) begin
        res_w_valid[pu_res[k].rob_entry] <= pu_res[k].w_valid;
        res_data[pu_res[k].rob_entry]    <= pu_res[k].w_data;
        res_vxsat[pu_res[k].rob_entry]   <= pu_res[k].vxsat;
      end
    end
  end

  // done set by results, cleared once the entry retires
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done <= '0;
    end else if (flush) begin
      done <= '0;
    end else begin
      for (int k = 0; k < rvv_rob_pkg::NUM_PU; k++) begin
        if (pu_fire[k]) begin
          done[pu_res[k].rob_entry] <= 1'b1;
        end
      end
      for (int k = 0; k < rvv_rob_pkg::NUM_RT_UOP; k++) begin
        if (pop[k]) begin
          done[ord_idx[k]] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trap_flag <= '0;
    end else if (flush) begin
      trap_flag <= '0;
    end else if (trap_valid && trap_ready) begin
      trap_flag[trap.trap_rob_entry] <= 1'b1;
    end
  end

  // retire slots, nothing retires behind a trapped uop
  for (genvar k = 0; k < rvv_rob_pkg::NUM_RT_UOP; k++) begin : g_rt
    if (k == 0) begin : g_oldest
      assign rt_valid[k] = entry_valid[k] & done[ord_idx[k]];
    end else begin : g_younger
      assign rt_valid[k] = rt_valid[k-1] & entry_valid[k] & done[ord_idx[k]]
                           & ~trap_flag[ord_idx[k-1]];
    end
    assign rt_uop[k].w_valid   = head_uop[k].w_valid & res_w_valid[ord_idx[k]];
    assign rt_uop[k].w_index   = head_uop[k].w_index;
    assign rt_uop[k].w_data    = res_data[ord_idx[k]];
    assign rt_uop[k].vxsat     = res_vxsat[ord_idx[k]];
    assign rt_uop[k].trap_flag = trap_flag[ord_idx[k]];
    assign rt_uop[k].tag       = head_uop[k].tag;
    assign rt_trap[k]          = trap_flag[ord_idx[k]] & pop[k];
  end

  assign flush = |rt_trap;

  // bypass in program order for operand forwarding
  for (genvar i = 0; i < rvv_rob_pkg::ROB_DEPTH; i++) begin : g_bypass
    assign bypass[i].valid   = entry_valid[i];
    assign bypass[i].w_valid = uop_info[i].w_valid & done[ord_idx[i]]
                               & res_w_valid[ord_idx[i]];
    assign bypass[i].w_index = uop_info[i].w_index;
    assign bypass[i].w_data  = res_data[ord_idx[i]];
  end

  for (genvar k = 0; k < rvv_rob_pkg::NUM_PU; k++) begin : g_pu_chk
    // entry_valid is rotated, so look up by offset from the oldest
    a_res_to_valid: assert property (@(posedge clk) disable iff (!rst_n)
      pu_fire[k] |-> entry_valid[rvv_rob_pkg::rob_idx_t'(pu_res[k].rob_entry - rptr)]);
    for (genvar j = k + 1; j < rvv_rob_pkg::NUM_PU; j++) begin : g_pair
      a_no_same_entry: assert property (@(posedge clk) disable iff (!rst_n)
        !(pu_fire[k] && pu_fire[j] && (pu_res[k].rob_entry == pu_res[j].rob_entry)));
    end
  end

endmodule

`default_nettype wire

// File: source/rvv_rob_info_fifo.sv
// ROB info ring: multi-push multi-pop storage of uop info with per-entry valid bits
`timescale 1ns/1ps
`default_nettype none

module rvv_rob_info_fifo (
  input  wire logic                                                  clk,
  input  wire logic                                                  rst_n,
  input  wire logic [rvv_rob_pkg::NUM_DP_UOP-1:0]                    push,
  input  wire rvv_rob_pkg::dp2rob_t [rvv_rob_pkg::NUM_DP_UOP-1:0]    datain,
  input  wire logic [rvv_rob_pkg::NUM_RT_UOP-1:0]                    pop,
  input  wire logic                                                  clear,
  output logic                                                       count_lt_depth,
  output logic                                                       count_lt_depth_m1,
  output rvv_rob_pkg::dp2rob_t [rvv_rob_pkg::NUM_RT_UOP-1:0]         dataout,
  output rvv_rob_pkg::dp2rob_t [rvv_rob_pkg::ROB_DEPTH-1:0]          fifo_data,
  output logic [rvv_rob_pkg::ROB_DEPTH-1:0]                          entry_valid,
  output rvv_rob_pkg::rob_idx_t                                      wptr,
  output rvv_rob_pkg::rob_idx_t                                      rptr
);

  rvv_rob_pkg::dp2rob_t  mem [rvv_rob_pkg::ROB_DEPTH];
  logic [rvv_rob_pkg::ROB_DEPTH-1:0] valid_q;
  rvv_rob_pkg::rob_cnt_t count;
  rvv_rob_pkg::rob_cnt_t n_push;
  rvv_rob_pkg::rob_cnt_t n_pop;
  rvv_rob_pkg::rob_idx_t wr_idx [rvv_rob_pkg::NUM_DP_UOP];
  // physical entry for each program-order position
  rvv_rob_pkg::rob_idx_t rd_idx [rvv_rob_pkg::ROB_DEPTH];

  always_comb begin
    n_push = '0;
    n_pop  = '0;
    for (int k = 0; k < rvv_rob_pkg::NUM_DP_UOP; k++) begin
      n_push = n_push + rvv_rob_pkg::rob_cnt_t'(push[k]);
    end
    for (int k = 0; k < rvv_rob_pkg::NUM_RT_UOP; k++) begin
      n_pop = n_pop + rvv_rob_pkg::rob_cnt_t'(pop[k]);
    end
  end

  assign count_lt_depth    = count < rvv_rob_pkg::rob_cnt_t'(rvv_rob_pkg::ROB_DEPTH);
  assign count_lt_depth_m1 = count < rvv_rob_pkg::rob_cnt_t'(rvv_rob_pkg::ROB_DEPTH - 1);

  for (genvar k = 0; k < rvv_rob_pkg::NUM_DP_UOP; k++) begin : g_wr_idx
    assign wr_idx[k] = wptr + rvv_rob_pkg::rob_idx_t'(k);
  end

  // rotate storage so position 0 is the oldest uop
  for (genvar i = 0; i < rvv_rob_pkg::ROB_DEPTH; i++) begin : g_order
    assign rd_idx[i]      = rptr + rvv_rob_pkg::rob_idx_t'(i);
    assign fifo_data[i]   = mem[rd_idx[i]];
    assign entry_valid[i] = valid_q[rd_idx[i]];
  end

  for (genvar k = 0; k < rvv_rob_pkg::NUM_RT_UOP; k++) begin : g_head
    assign dataout[k] = mem[rd_idx[k]];
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < rvv_rob_pkg::NUM_DP_UOP; k++) begin
      if (push[k]) begin
        mem[wr_idx[k]] <= datain[k];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr    <= '0;
      rptr    <= '0;
      count   <= '0;
    end else if (clear) begin
      // drop everything, the ring restarts at the write pointer
      valid_q <= '0;
      rptr    <= wptr;
      count   <= '0;
    end else begin
      for (int k = 0; k < rvv_rob_pkg::NUM_RT_UOP; k++) begin
        if (pop[k]) begin
          valid_q[rd_idx[k]] <= 1'b0;
        end
      end
      for (int k = 0; k < rvv_rob_pkg::NUM_DP_UOP; k++) begin
        if (push[k]) begin
          valid_q[wr_idx[k]] <= 1'b1;
        end
      end
      wptr  <= wptr + rvv_rob_pkg::rob_idx_t'(n_push);
      rptr  <= rptr + rvv_rob_pkg::rob_idx_t'(n_pop);
      count <= count + n_push - n_pop;
    end
  end

  // the ROB gates pushes with its ready outputs
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push[0] |-> count_lt_depth);

  a_no_push2_full: assert property (@(posedge clk) disable iff (!rst_n)
    push[1] |-> count_lt_depth_m1);

  for (genvar k = 0; k < rvv_rob_pkg::NUM_RT_UOP; k++) begin : g_pop_chk
    a_pop_valid: assert property (@(posedge clk) disable iff (!rst_n)
      pop[k] |-> entry_valid[k]);
  end

endmodule

`default_nettype wire

// File: source/rvv_rob_pkg.sv
// ROB package: sizes and the packed structs passed between dispatch, ROB and retire
`default_nettype none

package rvv_rob_pkg;

  // slots and ports per cycle
  localparam int NUM_DP_UOP = 2;
  localparam int NUM_RT_UOP = 2;
  localparam int NUM_PU     = 2;

  // reorder buffer geometry
  localparam int ROB_DEPTH = 8;
  localparam int ROB_IDX_W = 3;

  // register file and payload widths
  localparam int VREG_NUM   = 8;
  localparam int VREG_IDX_W = 3;
  localparam int DATA_W     = 32;
  localparam int TAG_W      = 8;

  // entry index, and an occupancy count that can hold ROB_DEPTH itself
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [ROB_IDX_W:0]   rob_cnt_t;

  // uop info pushed by dispatch
  typedef struct packed {
    logic                  w_valid;
    logic [VREG_IDX_W-1:0] w_index;
    logic [TAG_W-1:0]      tag;
  } dp2rob_t;

  // one result from a processing unit
  typedef struct packed {
    rob_idx_t          rob_entry;
    logic              w_valid;
    logic [DATA_W-1:0] w_data;
    logic              vxsat;
  } pu2rob_t;

  // one retire slot
  typedef struct packed {
    logic                  w_valid;
    logic [VREG_IDX_W-1:0] w_index;
    logic [DATA_W-1:0]     w_data;
    logic                  vxsat;
    logic                  trap_flag;
    logic [TAG_W-1:0]      tag;
  } rob2rt_t;

  // one bypass entry, w_valid means the result is already present
  typedef struct packed {
    logic                  valid;
    logic                  w_valid;
    logic [VREG_IDX_W-1:0] w_index;
    logic [DATA_W-1:0]     w_data;
  } rob2dp_t;

  typedef struct packed {
    rob_idx_t trap_rob_entry;
  } trap_t;

endpackage

`default_nettype wire
